// ==== filelist.f ====
hdl/cache_pkg.sv
hdl/cache_lru.sv
hdl/cache_set.sv
hdl/cache_ctrl.sv
hdl/cache_rsp_mux.sv
hdl/cache_top.sv
bench/mem_model.sv
bench/tb_cache_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the cache testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_cache_top \
  -f filelist.f -o sim_cache

./obj_dir/sim_cache | tee sim.log

grep -q "ALL TESTS PASSED" sim.log

// ==== bench/tb_cache_top.sv ====
`timescale 1ns/10ps

module tb_cache_top
  import cache_pkg::*;
();

  localparam int SEED = 32'hc972dd66;
  localparam int MAX_WAIT = 400;
  localparam int N_ROWS = 12;
  localparam int N_RANDOM = 60;

  typedef struct packed {
    host_op_e    op;
    logic [23:0] adr;
    logic [3:0]  sel;
    logic [31:0] data;
    logic        chk;    // Compare the read word
    int          n_rd;   // Expected memory reads, -1 for any
    int          n_wr;   // Expected write-backs, -1 for any
  } row_t;

  // Set 1 holds lines 1, 5 and 9 under tags 0, 1 and 2
  row_t rows [N_ROWS] = '{
    '{OP_READ,  24'h000010, 4'h0, 32'h00000000, 1'b1, 1, 0},   // Cold miss
    '{OP_WRITE, 24'h000014, 4'h5, 32'haabbccdd, 1'b0, 0, 0},
    '{OP_READ,  24'h000014, 4'h0, 32'h00000000, 1'b1, 0, 0},   // Merged bytes
    '{OP_READ,  24'h000050, 4'h0, 32'h00000000, 1'b1, 1, 0},
    '{OP_READ,  24'h000090, 4'h0, 32'h00000000, 1'b1, 1, 1},   // Dirty LRU victim
    '{OP_READ,  24'h000014, 4'h0, 32'h00000000, 1'b1, 1, 0},   // Clean victim
    '{OP_WRITE, 24'h000098, 4'hf, 32'h12345678, 1'b0, 0, 0},
    '{OP_WRITE, 24'h000020, 4'hc, 32'hdeadbeef, 1'b0, 1, 0},   // Write miss
    '{OP_FLUSH, 24'h000000, 4'h0, 32'h00000000, 1'b0, 0, 2},
    '{OP_READ,  24'h000098, 4'h0, 32'h00000000, 1'b1, 1, 0},
    '{OP_READ,  24'h000020, 4'h0, 32'h00000000, 1'b1, 1, 0},
    '{OP_READ,  24'h000014, 4'h0, 32'h00000000, 1'b1, 1, 0}
  };

  logic        clk;
  logic        rst;
  logic        host_req;
  host_req_t   host_cmd;
  logic        host_ack;
  host_rsp_t   host_rsp;
  logic        mem_req;
  mem_req_t    mem_cmd;
  logic        mem_ack;
  mem_rsp_t    mem_rsp;
  logic [31:0] ref_word [int];   // Latest host-visible word
  bit          dirty_line [int];  // Lines written since their fill
  logic [19:0] last_rd;
  int          rd_count;
  int          wr_count;
  int          checks;
  int          errors;
  int          seed;
  bit          timed_out;

  cache_top #(
    .SETS(4),
    .WAYS(2)
  ) dut (
    .clk      (clk),
    .rst      (rst),
    .host_req (host_req),
    .host_cmd (host_cmd),
    .host_ack (host_ack),
    .host_rsp (host_rsp),
    .mem_req  (mem_req),
    .mem_cmd  (mem_cmd),
    .mem_ack  (mem_ack),
    .mem_rsp  (mem_rsp)
  );

  mem_model #(
    .SEED(SEED)
  ) mem (
    .clk     (clk),
    .mem_req (mem_req),
    .mem_cmd (mem_cmd),
    .mem_ack (mem_ack),
    .mem_rsp (mem_rsp)
  );

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic logic [31:0] exp_word(input int wadr);
    if (ref_word.exists(wadr))
      return ref_word[wadr];
    return 32'(wadr) ^ 32'h5a5a0000;
  endfunction

  function automatic line_t exp_line(input int ladr);
    line_t l;
    for (int w = 0; w < WORDS_PER_LINE; w++)
      l[w] = exp_word(ladr * WORDS_PER_LINE + w);
    return l;
  endfunction

  task automatic check(input logic [127:0] got, input logic [127:0] exp, input string msg);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("Error at %0t: %s, got %0h, expected %0h", $time, msg, got, exp);
    end
  endtask

  // Each completed memory handshake
  always @(posedge clk)
  begin
    if (mem_req && mem_ack)
    begin
      if (mem_cmd.we)
      begin
        wr_count++;
        check(128'(dirty_line.exists(int'(mem_cmd.adr))), 128'(1),
              "write-back of a clean line");
        dirty_line.delete(int'(mem_cmd.adr));
        check(mem_cmd.data, exp_line(int'(mem_cmd.adr)), "write-back data");
      end
      else
      begin
        rd_count++;
        last_rd = mem_cmd.adr;
      end
    end
  end

  task automatic run_row(input row_t r);
    int          rd0;
    int          wr0;
    int          cyc;
    int          wadr;
    logic [31:0] w;
    rd0  = rd_count;
    wr0  = wr_count;
    wadr = int'(r.adr >> 2);
    host_cmd.op   = r.op;
    host_cmd.adr  = r.adr;
    host_cmd.sel  = r.sel;
    host_cmd.data = r.data;
    host_req      = 1'b1;
    cyc = 0;
    while (!host_ack && cyc < MAX_WAIT)
    begin
      @(posedge clk);
      #2;
      cyc++;
    end
    if (!host_ack)
    begin
      $display("Timeout: no host_ack for %s at address %h", r.op.name(), r.adr);
      errors++;
      timed_out = 1'b1;
      return;
    end
    if (r.chk)
      check(host_rsp.data, exp_word(wadr), "read data");
    if (r.op == OP_WRITE)
    begin
      w = exp_word(wadr);
      for (int b = 0; b < 4; b++)
        if (r.sel[b])
          w[8*b +: 8] = r.data[8*b +: 8];
      ref_word[wadr] = w;
      dirty_line[int'(r.adr >> 4)] = 1'b1;
    end
    if (r.op == OP_FLUSH)
      check(128'(dirty_line.num()), 128'(0), "dirty lines left by flush");
    if (r.n_rd >= 0)
      check(128'(rd_count - rd0), 128'(r.n_rd), "memory read count");
    if (r.n_wr >= 0)
      check(128'(wr_count - wr0), 128'(r.n_wr), "write-back count");
    if (r.n_rd == 1)
      check(128'(last_rd), 128'(r.adr[23:4]), "fill line address");
    if (r.op != OP_FLUSH && r.n_rd == 0 && r.n_wr == 0)
      check(128'(cyc - 1), 128'(3), "hit latency");   // Edge that saw req to ack
    host_req = 1'b0;
    cyc = 0;
    while (host_ack && cyc < MAX_WAIT)
    begin
      @(posedge clk);
      #2;
      cyc++;
    end
    if (host_ack)
    begin
      $display("Timeout: host_ack stayed high after host_req dropped");
      errors++;
      timed_out = 1'b1;
    end
  endtask

  initial
  begin
    row_t r;
    seed      = SEED;
    rst       = 1'b1;
    host_req  = 1'b0;
    host_cmd  = '0;
    rd_count  = 0;
    wr_count  = 0;
    checks    = 0;
    errors    = 0;
    timed_out = 1'b0;
    last_rd   = '0;
    repeat (10) @(posedge clk);
    #2;
    rst = 1'b0;

    foreach (rows[i])
      if (!timed_out)
        run_row(rows[i]);

    // Random reads and writes over 64 lines
    for (int i = 0; i < N_RANDOM && !timed_out; i++)
    begin
      r.op   = ($random(seed) & 1) ? OP_WRITE : OP_READ;
      r.adr  = 24'($random(seed)) & 24'h0003fc;
      r.sel  = 4'($random(seed));
      r.data = $random(seed);
      r.chk  = r.op == OP_READ;
      r.n_rd = -1;
      r.n_wr = -1;
      run_row(r);
    end

    errors += mem.stuck_errors;
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("ALL TESTS PASSED");
    else
      $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

// ==== bench/mem_model.sv ====
`timescale 1ns/10ps

module mem_model
  import cache_pkg::*;
#(
  parameter int SEED = 32'hc972dd66,
  parameter int MAX_WAIT = 100
) (
  input  logic     clk,
  input  logic     mem_req,
  input  mem_req_t mem_cmd,
  output logic     mem_ack,
  output mem_rsp_t mem_rsp
);

  line_t    lines [int];   // Only lines that were written
  int       seed;
  int       delay;
  int       wait_cnt;
  int       stuck_errors;
  mem_req_t cmd;

  // Untouched words hold their word address XOR a fixed pattern
  function automatic line_t read_line(input int ladr);
    line_t l;
    if (lines.exists(ladr))
      return lines[ladr];
    for (int w = 0; w < WORDS_PER_LINE; w++)
      l[w] = 32'(ladr * WORDS_PER_LINE + w) ^ 32'h5a5a0000;
    return l;
  endfunction

  initial
  begin
    mem_ack      = 1'b0;
    mem_rsp      = '0;
    seed         = SEED;
    stuck_errors = 0;
  end

  always
  begin
    @(posedge clk);
    #2;
    if (mem_req && !mem_ack)
    begin
      cmd   = mem_cmd;
      delay = $random(seed) & 3;   // 0 to 3 extra cycles
      repeat (delay) @(posedge clk);
      if (delay > 0)
        #2;
      if (cmd.we)
        lines[int'(cmd.adr)] = cmd.data;
      else
        mem_rsp.data = read_line(int'(cmd.adr));
      mem_ack  = 1'b1;
      wait_cnt = 0;
      while (mem_req && wait_cnt < MAX_WAIT)
      begin
        @(posedge clk);
        #2;
        wait_cnt++;
      end
      if (mem_req)
      begin
        $display("Memory model: the cache never released mem_req");
        stuck_errors++;
      end
      mem_ack = 1'b0;
    end
  end

endmodule

// ==== hdl/cache_top.sv ====
`timescale 1ns/10ps

module cache_top
  import cache_pkg::*;
#(
  parameter int SETS = 4,
  parameter int WAYS = 2
) (
  input  logic      clk,
  input  logic      rst,
  input  logic      host_req,
  input  host_req_t host_cmd,
  output logic      host_ack,
  output host_rsp_t host_rsp,
  output logic      mem_req,
  output mem_req_t  mem_cmd,
  input  logic      mem_ack,
  input  mem_rsp_t  mem_rsp
);

  localparam int TAG_W = ADR_W - 4 - $clog2(SETS);

  ctrl_state_e                  state;
  logic [SETS-1:0]              set_target;
  host_req_t                    stg_cmd;
  mem_rsp_t                     fill;
  logic                         fill_valid;
  logic [$clog2(WAYS)-1:0]      flush_way;
  logic                         flush_done;
  logic                         sel_hit;
  logic                         sel_dirty;
  logic                         sel_valid;
  mem_req_t                     wb_cmd;
  logic [SETS-1:0]              hit_v;
  logic [SETS-1:0]              dirty_v;
  logic [SETS-1:0]              valid_v;
  logic [SETS-1:0][TAG_W-1:0]   tag_v;
  line_t [SETS-1:0]             line_v;

  cache_ctrl #(
    .SETS(SETS),
    .WAYS(WAYS)
  ) u_ctrl (
    .clk        (clk),
    .rst        (rst),
    .host_req   (host_req),
    .host_cmd   (host_cmd),
    .host_ack   (host_ack),
    .mem_req    (mem_req),
    .mem_cmd    (mem_cmd),
    .mem_ack    (mem_ack),
    .mem_rsp    (mem_rsp),
    .state      (state),
    .set_target (set_target),
    .stg_cmd    (stg_cmd),
    .fill       (fill),
    .fill_valid (fill_valid),
    .flush_way  (flush_way),
    .flush_done (flush_done),
    .sel_hit    (sel_hit),
    .sel_dirty  (sel_dirty),
    .sel_valid  (sel_valid),
    .wb_cmd     (wb_cmd)
  );

  for (genvar s = 0; s < SETS; s++)
  begin : g_set
    cache_set #(
      .SETS(SETS),
      .WAYS(WAYS)
    ) u_set (
      .clk         (clk),
      .rst         (rst),
      .set_target  (set_target[s]),
      .state       (state),
      .cmd         (stg_cmd),
      .fill        (fill),
      .fill_valid  (fill_valid),
      .flush_way   (flush_way),
      .flush_done  (flush_done),
      .hit         (hit_v[s]),
      .entry_dirty (dirty_v[s]),
      .entry_valid (valid_v[s]),
      .entry_tag   (tag_v[s]),
      .entry_line  (line_v[s])
    );
  end

  cache_rsp_mux #(
    .SETS(SETS)
  ) u_mux (
    .set_target (set_target),
    .cmd        (stg_cmd),
    .hit_v      (hit_v),
    .dirty_v    (dirty_v),
    .valid_v    (valid_v),
    .tag_v      (tag_v),
    .line_v     (line_v),
    .sel_hit    (sel_hit),
    .sel_dirty  (sel_dirty),
    .sel_valid  (sel_valid),
    .host_rsp   (host_rsp),
    .wb_cmd     (wb_cmd)
  );

endmodule

// ==== hdl/cache_rsp_mux.sv ====
`timescale 1ns/10ps

module cache_rsp_mux
  import cache_pkg::*;
#(
  parameter int SETS = 4
) (
  input  logic [SETS-1:0]                         set_target,
  input  host_req_t                               cmd,
  input  logic [SETS-1:0]                         hit_v,
  input  logic [SETS-1:0]                         dirty_v,
  input  logic [SETS-1:0]                         valid_v,
  input  logic [SETS-1:0][ADR_W-$clog2(SETS)-5:0] tag_v,
  input  line_t [SETS-1:0]                        line_v,
  output logic                                    sel_hit,
  output logic                                    sel_dirty,
  output logic                                    sel_valid,
  output host_rsp_t                               host_rsp,
  output mem_req_t                                wb_cmd
);

  localparam int LOG_SETS = $clog2(SETS);
  localparam int TAG_W = ADR_W - 4 - LOG_SETS;
  localparam int LADR_W = ADR_W - 4;

  logic [TAG_W-1:0]  sel_tag;
  logic [LADR_W-1:0] set_idx;
  line_t             sel_line;

  always_comb
  begin
    sel_tag  = '0;
    sel_line = '0;
    set_idx  = '0;
    for (int s = 0; s < SETS; s++)
      if (set_target[s])
      begin
        sel_tag  = tag_v[s];
        sel_line = line_v[s];
        set_idx  = LADR_W'(s);
      end
  end

  assign sel_hit   = |(hit_v & set_target);
  assign sel_dirty = |(dirty_v & set_target);
  assign sel_valid = |(valid_v & set_target);

  assign host_rsp.data = sel_line[cmd.adr[3:2]];

  // Victim line address is tag above set index
  assign wb_cmd.we   = 1'b1;
  assign wb_cmd.adr  = (LADR_W'(sel_tag) << LOG_SETS) | set_idx;
  assign wb_cmd.data = sel_line;

endmodule

// ==== hdl/cache_ctrl.sv ====
`timescale 1ns/10ps

module cache_ctrl
  import cache_pkg::*;
#(
  parameter int SETS = 4,
  parameter int WAYS = 2
) (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    host_req,
  input  host_req_t               host_cmd,
  output logic                    host_ack,
  output logic                    mem_req,
  output mem_req_t                mem_cmd,
  input  logic                    mem_ack,
  input  mem_rsp_t                mem_rsp,
  output ctrl_state_e             state,
  output logic [SETS-1:0]         set_target,
  output host_req_t               stg_cmd,
  output mem_rsp_t                fill,
  output logic                    fill_valid,
  output logic [$clog2(WAYS)-1:0] flush_way,
  output logic                    flush_done,
  input  logic                    sel_hit,
  input  logic                    sel_dirty,
  input  logic                    sel_valid,
  input  mem_req_t                wb_cmd
);

  localparam int WAY_W = $clog2(WAYS);
  localparam int IDX_W = (SETS > 1) ? $clog2(SETS) : 1;

  logic [IDX_W-1:0] fl_set;      // Set being walked by flush-all
  logic             mem_acked;
  logic             mem_done;
  logic             walk_last;

  assign mem_done   = mem_acked && !mem_ack;
  assign walk_last  = fl_set == IDX_W'(SETS - 1) && flush_way == WAY_W'(WAYS - 1);
  assign flush_done = state == ST_FLUSHALL_DONE;

  always_comb
  begin
    if (state inside {ST_FLUSHALL, ST_FLUSHALL_WB, ST_FLUSHALL_DONE})
      set_target = SETS'(1) << fl_set;
    else
      set_target = SETS'(1) << ((stg_cmd.adr >> 4) & ADR_W'(SETS - 1));
  end

  always_ff @(posedge clk)
  begin
    fill_valid <= 1'b0;

    // Memory side, second half of the four-phase cycle
    if (mem_req && mem_ack)
    begin
      mem_req    <= 1'b0;
      mem_acked  <= 1'b1;
      fill       <= mem_rsp;
      fill_valid <= !mem_cmd.we;
    end
    if (mem_done)
      mem_acked <= 1'b0;

    case (state)
      ST_IDLE:
        if (host_req)
        begin
          stg_cmd   <= host_cmd;
          fl_set    <= '0;
          flush_way <= '0;
          state     <= (host_cmd.op == OP_FLUSH) ? ST_FLUSHALL : ST_LOOKUP;
        end
      ST_LOOKUP:
        if (sel_hit)
          state <= ST_UPDATE;
        else if (sel_valid && sel_dirty)
        begin
          mem_req <= 1'b1;   // Write back the victim
          mem_cmd <= wb_cmd;
          state   <= ST_FLUSH;
        end
        else
          state <= ST_LOAD;
      ST_FLUSH:
        if (mem_done)
          state <= ST_LOAD;
      ST_LOAD:
      begin
        mem_req      <= 1'b1;
        mem_cmd.we   <= 1'b0;
        mem_cmd.adr  <= stg_cmd.adr[ADR_W-1:4];
        mem_cmd.data <= '0;
        state        <= ST_LOAD_PENDING;
      end
      ST_LOAD_PENDING:
        if (mem_done)
          state <= ST_UPDATE;
      ST_UPDATE:
        state <= ST_RESPOND;
      ST_RESPOND:
        if (!host_ack)
          host_ack <= 1'b1;
        else if (!host_req)
        begin
          host_ack <= 1'b0;
          state    <= ST_IDLE;
        end
      ST_FLUSHALL:
        if (sel_valid && sel_dirty)
        begin
          mem_req <= 1'b1;
          mem_cmd <= wb_cmd;
          state   <= ST_FLUSHALL_WB;
        end
        else if (walk_last)
          state <= ST_FLUSHALL_DONE;
        else
        begin
          flush_way <= flush_way + 1'b1;
          if (flush_way == WAY_W'(WAYS - 1))
            fl_set <= fl_set + 1'b1;
        end
      ST_FLUSHALL_WB:
        if (mem_done)
        begin
          if (walk_last)
            state <= ST_FLUSHALL_DONE;
          else
          begin
            flush_way <= flush_way + 1'b1;
            if (flush_way == WAY_W'(WAYS - 1))
              fl_set <= fl_set + 1'b1;
            state <= ST_FLUSHALL;
          end
        end
      ST_FLUSHALL_DONE:
        state <= ST_RESPOND;   // All sets invalidate this cycle
      default:
        state <= ST_IDLE;
    endcase

    if (rst)
    begin
      state      <= ST_IDLE;
      host_ack   <= 1'b0;
      mem_req    <= 1'b0;
      mem_acked  <= 1'b0;
      fill_valid <= 1'b0;
      fl_set     <= '0;
      flush_way  <= '0;
    end
  end

endmodule

// ==== hdl/cache_set.sv ====
`timescale 1ns/10ps

module cache_set
  import cache_pkg::*;
#(
  parameter int SETS = 4,
  parameter int WAYS = 2
) (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            set_target,
  input  ctrl_state_e                     state,
  input  host_req_t                       cmd,
  input  mem_rsp_t                        fill,
  input  logic                            fill_valid,
  input  logic [$clog2(WAYS)-1:0]         flush_way,
  input  logic                            flush_done,
  output logic                            hit,
  output logic                            entry_dirty,
  output logic                            entry_valid,
  output logic [ADR_W-$clog2(SETS)-5:0]   entry_tag,
  output line_t                           entry_line
);

  localparam int WAY_W = $clog2(WAYS);
  localparam int TAG_LSB = 4 + $clog2(SETS);
  localparam int TAG_W = ADR_W - TAG_LSB;

  typedef struct packed {
    logic             valid;
    logic             dirty;
    logic [TAG_W-1:0] tag;
    line_t            line;
  } entry_t;

  entry_t [WAYS-1:0] ways;
  logic [WAY_W-1:0]  sel_way;    // Way chosen in lookup
  logic [WAY_W-1:0]  pick_way;
  logic [WAY_W-1:0]  cur_way;
  logic [WAY_W-1:0]  lru_way;
  logic [TAG_W-1:0]  cmd_tag;
  logic [WAYS-1:0]   match;
  logic [1:0]        word;
  logic              flushall;
  logic              touch;
  line_t             merged;

  assign cmd_tag  = cmd.adr[ADR_W-1:TAG_LSB];
  assign word     = cmd.adr[3:2];
  assign flushall = state inside {ST_FLUSHALL, ST_FLUSHALL_WB, ST_FLUSHALL_DONE};
  assign touch    = set_target && state == ST_LOOKUP;

  cache_lru #(
    .WAYS(WAYS)
  ) u_lru (
    .clk       (clk),
    .rst       (rst),
    .touch     (touch),
    .touch_way (pick_way),
    .lru_way   (lru_way)
  );

  always_comb
  begin
    match = '0;
    for (int w = 0; w < WAYS; w++)
      match[w] = ways[w].valid && ways[w].tag == cmd_tag;
    hit = |match;

    // Hit way, else first invalid way, else LRU
    pick_way = lru_way;
    for (int w = WAYS - 1; w >= 0; w--)
      if (!ways[w].valid)
        pick_way = WAY_W'(w);
    for (int w = WAYS - 1; w >= 0; w--)
      if (match[w])
        pick_way = WAY_W'(w);

    if (state == ST_LOOKUP)
      cur_way = pick_way;
    else if (flushall)
      cur_way = flush_way;
    else
      cur_way = sel_way;
  end

  assign entry_valid = ways[cur_way].valid;
  assign entry_dirty = ways[cur_way].dirty;
  assign entry_tag   = ways[cur_way].tag;
  assign entry_line  = ways[cur_way].line;

  always_comb
  begin
    merged = ways[cur_way].line;
    for (int b = 0; b < 4; b++)
      if (cmd.sel[b])
        merged[word][8*b +: 8] = cmd.data[8*b +: 8];
  end

  always_ff @(posedge clk)
  begin
    if (touch)
      sel_way <= pick_way;

    if (set_target)
    begin
      case (state)
        ST_FLUSH:
          ways[cur_way].valid <= 1'b0;   // Victim already written back
        ST_LOAD:
        begin
          ways[cur_way].valid <= 1'b0;
          ways[cur_way].dirty <= 1'b0;
          ways[cur_way].tag   <= cmd_tag;
        end
        ST_LOAD_PENDING:
          if (fill_valid)
          begin
            ways[cur_way].valid <= 1'b1;
            ways[cur_way].line  <= fill.data;
          end
        ST_UPDATE:
          if (cmd.op == OP_WRITE)
          begin
            ways[cur_way].dirty <= 1'b1;
            ways[cur_way].line  <= merged;
          end
        default:
          ;
      endcase
    end

    if (rst || flush_done)
    begin
      for (int w = 0; w < WAYS; w++)
      begin
        ways[w].valid <= 1'b0;
        ways[w].dirty <= 1'b0;
      end
    end
    if (rst)
      sel_way <= '0;
  end

endmodule

// ==== hdl/cache_lru.sv ====
`timescale 1ns/10ps

module cache_lru #(
  parameter int WAYS = 2
) (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    touch,
  input  logic [$clog2(WAYS)-1:0] touch_way,
  output logic [$clog2(WAYS)-1:0] lru_way
);

  localparam int WAY_W = $clog2(WAYS);
  localparam int PAIRS = WAYS * (WAYS - 1) / 2;

  logic [PAIRS-1:0] order;       // Set when the lower way of a pair is newer
  logic [PAIRS-1:0] order_next;

  function automatic int pidx(input int lo, input int hi);
    return lo * WAYS - lo * (lo + 1) / 2 + hi - lo - 1;
  endfunction

  always_comb
  begin
    order_next = order;
    for (int i = 0; i < WAYS; i++)
      for (int j = i + 1; j < WAYS; j++)
        if (int'(touch_way) == i)
          order_next[pidx(i, j)] = 1'b1;
        else if (int'(touch_way) == j)
          order_next[pidx(i, j)] = 1'b0;
  end

  // Scan downward so the lowest oldest way wins
  always_comb
  begin
    logic oldest;
    lru_way = '0;
    for (int w = WAYS - 1; w >= 0; w--)
    begin
      oldest = 1'b1;
      for (int k = 0; k < WAYS; k++)
        if (k > w && order[pidx(w, k)])
          oldest = 1'b0;
        else if (k < w && !order[pidx(k, w)])
          oldest = 1'b0;
      if (oldest)
        lru_way = WAY_W'(w);
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      order <= '0;
    else if (touch)
      order <= order_next;
  end

endmodule

// ==== hdl/cache_pkg.sv ====
package cache_pkg;

  localparam int ADR_W = 24;
  localparam int WORDS_PER_LINE = 4;

  typedef logic [WORDS_PER_LINE-1:0][31:0] line_t;

  typedef enum logic [1:0] {
    OP_READ,
    OP_WRITE,
    OP_FLUSH
  } host_op_e;

  typedef struct packed {
    host_op_e         op;
    logic [ADR_W-1:0] adr;   // Byte address
    logic [3:0]       sel;
    logic [31:0]      data;
  } host_req_t;

  typedef struct packed {
    logic [31:0] data;
  } host_rsp_t;

  typedef struct packed {
    logic             we;
    logic [ADR_W-5:0] adr;   // Line address
    line_t            data;
  } mem_req_t;

  typedef struct packed {
    line_t data;
  } mem_rsp_t;

  typedef enum logic [3:0] {
    ST_IDLE,
    ST_LOOKUP,
    ST_FLUSH,
    ST_LOAD,
    ST_LOAD_PENDING,
    ST_UPDATE,
    ST_RESPOND,
    ST_FLUSHALL,
    ST_FLUSHALL_WB,
    ST_FLUSHALL_DONE
  } ctrl_state_e;

endpackage
